/* src/dmac_macros.svh */
// dmac constants
// datapath widths, queue sizing, memory credits and register map
`ifndef DMAC_MACROS_SVH
`define DMAC_MACROS_SVH

// ------------------------------------------------
// datapath
`define DMAC_ADDR_W 16
`define DMAC_DATA_W 32

// ------------------------------------------------
// buffering and flow control
`define DMAC_QUEUE_DEPTH 2
`define DMAC_MEM_CREDITS 4

// ------------------------------------------------
// register map, word offsets
`define DMAC_REG_ADDR_W 4
`define DMAC_REG_SRC 4'd0
`define DMAC_REG_DST 4'd1
`define DMAC_REG_LEN 4'd2
`define DMAC_REG_SRC_STRIDE 4'd3
`define DMAC_REG_DST_STRIDE 4'd4
`define DMAC_REG_REPS 4'd5
`define DMAC_REG_NEXT_ID 4'd6
`define DMAC_REG_DONE_ID 4'd7
`define DMAC_REG_STATUS 4'd8

`endif

/* src/dmac_pkg.sv */
// dmac shared types
// register port, job, burst and memory port structs plus FSM states
`include "dmac_macros.svh"

package dmac_pkg;

  // register offsets, 9 registers need a 4 bit code
  typedef enum logic [`DMAC_REG_ADDR_W-1:0] {
    SRC        = `DMAC_REG_SRC,
    DST        = `DMAC_REG_DST,
    LEN        = `DMAC_REG_LEN,
    SRC_STRIDE = `DMAC_REG_SRC_STRIDE,
    DST_STRIDE = `DMAC_REG_DST_STRIDE,
    REPS       = `DMAC_REG_REPS,
    NEXT_ID    = `DMAC_REG_NEXT_ID,
    DONE_ID    = `DMAC_REG_DONE_ID,
    STATUS     = `DMAC_REG_STATUS
  } reg_addr_e;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    reg_addr_e               addr;
    logic [`DMAC_DATA_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                    ready;
    logic                    rvalid;
    logic [`DMAC_DATA_W-1:0] rdata;
  } cfg_rsp_t;

  // two-dimensional job, all fields in words
  typedef struct packed {
    logic [`DMAC_ADDR_W-1:0] src;
    logic [`DMAC_ADDR_W-1:0] dst;
    logic [`DMAC_ADDR_W-1:0] len;
    logic [`DMAC_ADDR_W-1:0] src_stride;
    logic [`DMAC_ADDR_W-1:0] dst_stride;
    logic [`DMAC_ADDR_W-1:0] reps;
  } nd_job_t;

  typedef struct packed {
    logic [`DMAC_ADDR_W-1:0] src;
    logic [`DMAC_ADDR_W-1:0] dst;
    logic [`DMAC_ADDR_W-1:0] len;
  } burst_t;

  typedef struct packed {
    logic                    valid;
    logic                    we;
    logic [`DMAC_ADDR_W-1:0] addr;
    logic [`DMAC_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                    rvalid;
    logic [`DMAC_DATA_W-1:0] rdata;
    logic                    credit;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WAIT_DATA,
    WRITE
  } copy_state_e;

endpackage

/* src/dmac_reg_frontend.sv */
// dmac register frontend
// holds the job configuration, answers reads and launches jobs on NEXT_ID
`timescale 1ns/1ps
`include "dmac_macros.svh"

module dmac_reg_frontend import dmac_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  cfg_req_t                cfg_req_i,
  output cfg_rsp_t                cfg_rsp_o,
  output nd_job_t                 job_o,
  output logic                    job_valid_o,
  input  logic                    job_ready_i,
  input  logic [`DMAC_DATA_W-1:0] next_id_i,
  input  logic [`DMAC_DATA_W-1:0] done_id_i,
  input  logic                    busy_i
);

  logic [`DMAC_ADDR_W-1:0] src_q;
  logic [`DMAC_ADDR_W-1:0] dst_q;
  logic [`DMAC_ADDR_W-1:0] len_q;
  logic [`DMAC_ADDR_W-1:0] src_stride_q;
  logic [`DMAC_ADDR_W-1:0] dst_stride_q;
  logic [`DMAC_ADDR_W-1:0] reps_q;
  logic [`DMAC_ADDR_W-1:0] wr_val;
  logic [`DMAC_DATA_W-1:0] rdata_d;
  logic [`DMAC_DATA_W-1:0] rdata_q;
  logic                    rvalid_q;
  logic                    req_ready;
  logic                    accept;

  assign wr_val = cfg_req_i.wdata[`DMAC_ADDR_W-1:0];

  // a launch waits while the queue is full
  assign req_ready   = cfg_req_i.write || (cfg_req_i.addr != NEXT_ID) || job_ready_i;
  assign accept      = cfg_req_i.valid && req_ready;
  assign job_valid_o = cfg_req_i.valid && !cfg_req_i.write && (cfg_req_i.addr == NEXT_ID);

  assign job_o.src        = src_q;
  assign job_o.dst        = dst_q;
  assign job_o.len        = len_q;
  assign job_o.src_stride = src_stride_q;
  assign job_o.dst_stride = dst_stride_q;
  assign job_o.reps       = reps_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
    end else if (accept && cfg_req_i.write) begin
      case (cfg_req_i.addr)
        SRC:        src_q        <= wr_val;
        DST:        dst_q        <= wr_val;
        LEN:        len_q        <= wr_val;
        SRC_STRIDE: src_stride_q <= wr_val;
        DST_STRIDE: dst_stride_q <= wr_val;
        REPS:       reps_q       <= wr_val;
        default: ;
      endcase
    end
  end

  // read mux
  always_comb begin
    rdata_d = '0;
    case (cfg_req_i.addr)
      SRC:        rdata_d[`DMAC_ADDR_W-1:0] = src_q;
      DST:        rdata_d[`DMAC_ADDR_W-1:0] = dst_q;
      LEN:        rdata_d[`DMAC_ADDR_W-1:0] = len_q;
      SRC_STRIDE: rdata_d[`DMAC_ADDR_W-1:0] = src_stride_q;
      DST_STRIDE: rdata_d[`DMAC_ADDR_W-1:0] = dst_stride_q;
      REPS:       rdata_d[`DMAC_ADDR_W-1:0] = reps_q;
      NEXT_ID:    rdata_d = next_id_i;
      DONE_ID:    rdata_d = done_id_i;
      STATUS:     rdata_d[0] = busy_i;
      default: ;
    endcase
  end

  // ------------------------------------------------
  // one cycle read response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept && !cfg_req_i.write;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_rsp_o.ready  = req_ready;
  assign cfg_rsp_o.rvalid = rvalid_q;
  assign cfg_rsp_o.rdata  = rdata_q;

endmodule

/* src/dmac_id_counter.sv */
// dmac transfer id counter
// next id to hand out and number of completed jobs
`timescale 1ns/1ps
`include "dmac_macros.svh"

module dmac_id_counter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    issue_i,
  input  logic                    retire_i,
  output logic [`DMAC_DATA_W-1:0] next_id_o,
  output logic [`DMAC_DATA_W-1:0] done_id_o
);

  logic [`DMAC_DATA_W-1:0] next_q;
  logic [`DMAC_DATA_W-1:0] done_q;

  // first launched job gets id 1
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      next_q <= {{(`DMAC_DATA_W-1){1'b0}}, 1'b1};
      done_q <= '0;
    end else begin
      if (issue_i) begin
        next_q <= next_q + 1'b1;
      end
      if (retire_i) begin
        done_q <= done_q + 1'b1;
      end
    end
  end

  assign next_id_o = next_q;
  assign done_id_o = done_q;

endmodule

/* src/dmac_job_queue.sv */
// dmac job queue
// small FIFO between the register frontend and the midend
`timescale 1ns/1ps
`include "dmac_macros.svh"

module dmac_job_queue import dmac_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  nd_job_t job_i,
  input  logic    valid_i,
  output logic    ready_o,
  output nd_job_t job_o,
  output logic    valid_o,
  input  logic    ready_i
);

  localparam int unsigned Depth = `DMAC_QUEUE_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  nd_job_t         mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    ptr_next = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = (count_q != CntW'(Depth));
  assign valid_o = (count_q != '0);
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;
  assign job_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= job_i;
    end
  end

endmodule

/* src/dmac_nd_midend.sv */
// dmac nd midend
// splits a 2d job into one burst per repetition and reports job completion
`timescale 1ns/1ps
`include "dmac_macros.svh"

module dmac_nd_midend import dmac_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  nd_job_t job_i,
  input  logic    job_valid_i,
  output logic    job_ready_o,
  output burst_t  burst_o,
  output logic    burst_valid_o,
  input  logic    burst_ready_i,
  input  logic    burst_done_i,
  output logic    job_done_o,
  output logic    busy_o
);

  localparam int unsigned AddrW = `DMAC_ADDR_W;

  logic             active_q;
  logic             burst_valid_q;
  logic             zero_done_q;
  logic [AddrW-1:0] src_q;
  logic [AddrW-1:0] dst_q;
  logic [AddrW-1:0] len_q;
  logic [AddrW-1:0] src_stride_q;
  logic [AddrW-1:0] dst_stride_q;
  logic [AddrW-1:0] reps_left_q;
  logic             take;
  logic             is_empty;
  logic             last_rep;

  // one job at a time, ready only when idle
  assign job_ready_o = !active_q;
  assign take        = job_valid_i && !active_q;
  assign is_empty    = (job_i.len == '0) || (job_i.reps == '0);
  assign last_rep    = (reps_left_q == AddrW'(1));

  // ------------------------------------------------
  // control
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q      <= 1'b0;
      burst_valid_q <= 1'b0;
      zero_done_q   <= 1'b0;
    end else begin
      // empty jobs finish the cycle after they are taken
      zero_done_q <= take && is_empty;
      if (take && !is_empty) begin
        active_q      <= 1'b1;
        burst_valid_q <= 1'b1;
      end
      if (burst_valid_q && burst_ready_i) begin
        burst_valid_q <= 1'b0;
      end
      if (burst_done_i) begin
        if (last_rep) begin
          active_q <= 1'b0;
        end else begin
          burst_valid_q <= 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------
  // burst addresses, stepped by the strides
  always_ff @(posedge clk_i) begin
    if (take) begin
      src_q        <= job_i.src;
      dst_q        <= job_i.dst;
      len_q        <= job_i.len;
      src_stride_q <= job_i.src_stride;
      dst_stride_q <= job_i.dst_stride;
      reps_left_q  <= job_i.reps;
    end else if (burst_done_i && !last_rep) begin
      src_q       <= src_q + src_stride_q;
      dst_q       <= dst_q + dst_stride_q;
      reps_left_q <= reps_left_q - 1'b1;
    end
  end

  assign burst_o.src   = src_q;
  assign burst_o.dst   = dst_q;
  assign burst_o.len   = len_q;
  assign burst_valid_o = burst_valid_q;

  assign job_done_o = zero_done_q || (burst_done_i && last_rep);
  assign busy_o     = active_q || zero_done_q;

endmodule

/* src/dmac_copy_engine.sv */
// dmac copy engine
// moves a burst word by word, read then write, under memory credits
`timescale 1ns/1ps
`include "dmac_macros.svh"

module dmac_copy_engine import dmac_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  burst_t   burst_i,
  input  logic     burst_valid_i,
  output logic     burst_ready_o,
  output logic     burst_done_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     busy_o
);

  localparam int unsigned Credits = `DMAC_MEM_CREDITS;
  localparam int unsigned CredW   = $clog2(Credits + 1);

  copy_state_e             state_q;
  copy_state_e             state_d;
  logic [`DMAC_ADDR_W-1:0] src_q;
  logic [`DMAC_ADDR_W-1:0] dst_q;
  logic [`DMAC_ADDR_W-1:0] left_q;
  logic [`DMAC_DATA_W-1:0] data_q;
  logic [CredW-1:0]        credits_q;
  logic                    have_credit;
  logic                    send;
  logic                    last_word;

  assign have_credit = (credits_q != '0);
  assign last_word   = (left_q == {{(`DMAC_ADDR_W-1){1'b0}}, 1'b1});

  always_comb begin
    state_d         = state_q;
    mem_req_o.valid = 1'b0;
    mem_req_o.we    = 1'b0;
    mem_req_o.addr  = src_q;
    mem_req_o.wdata = data_q;
    burst_done_o    = 1'b0;
    case (state_q)
      IDLE: begin
        if (burst_valid_i) begin
          state_d = READ;
        end
      end
      READ: begin
        // stall here without credits
        mem_req_o.valid = have_credit;
        if (have_credit) begin
          state_d = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (mem_rsp_i.rvalid) begin
          state_d = WRITE;
        end
      end
      WRITE: begin
        mem_req_o.valid = have_credit;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = dst_q;
        if (have_credit) begin
          burst_done_o = last_word;
          state_d      = last_word ? IDLE : READ;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign send          = mem_req_o.valid;
  assign burst_ready_o = (state_q == IDLE);
  assign busy_o        = (state_q != IDLE);

  // ------------------------------------------------
  // state and credit counter
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      credits_q <= CredW'(Credits);
    end else begin
      state_q   <= state_d;
      credits_q <= credits_q + CredW'(mem_rsp_i.credit) - CredW'(send);
    end
  end

  // addresses, word count and data buffer
  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: begin
        if (burst_valid_i) begin
          src_q  <= burst_i.src;
          dst_q  <= burst_i.dst;
          left_q <= burst_i.len;
        end
      end
      READ: begin
        if (send) begin
          src_q <= src_q + 1'b1;
        end
      end
      WAIT_DATA: begin
        if (mem_rsp_i.rvalid) begin
          data_q <= mem_rsp_i.rdata;
        end
      end
      default: begin
        if (send) begin
          dst_q  <= dst_q + 1'b1;
          left_q <= left_q - 1'b1;
        end
      end
    endcase
  end

endmodule

/* src/dmac_top.sv */
// dmac top level
// register frontend, id counter, job queue, midend and copy engine
`timescale 1ns/1ps
`include "dmac_macros.svh"

module dmac_top import dmac_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  cfg_req_t cfg_req_i,
  output cfg_rsp_t cfg_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     done_event_o,
  output logic     busy_o
);

  nd_job_t                 fe_job;
  logic                    fe_valid;
  logic                    fe_ready;
  nd_job_t                 q_job;
  logic                    q_valid;
  logic                    q_ready;
  burst_t                  burst;
  logic                    burst_valid;
  logic                    burst_ready;
  logic                    burst_done;
  logic                    job_done;
  logic                    mid_busy;
  logic                    eng_busy;
  logic [`DMAC_DATA_W-1:0] next_id;
  logic [`DMAC_DATA_W-1:0] done_id;

  assign done_event_o = job_done;
  assign busy_o       = q_valid | mid_busy | eng_busy;

  // ------------------------------------------------
  // frontend and ids
  dmac_reg_frontend i_reg_frontend (
    .clk_i,
    .reset_i,
    .cfg_req_i,
    .cfg_rsp_o,
    .job_o      (fe_job),
    .job_valid_o(fe_valid),
    .job_ready_i(fe_ready),
    .next_id_i  (next_id),
    .done_id_i  (done_id),
    .busy_i     (busy_o)
  );

  dmac_id_counter i_id_counter (
    .clk_i,
    .reset_i,
    .issue_i  (fe_valid & fe_ready),
    .retire_i (job_done),
    .next_id_o(next_id),
    .done_id_o(done_id)
  );

  // ------------------------------------------------
  // queue, midend and engine
  dmac_job_queue i_job_queue (
    .clk_i,
    .reset_i,
    .job_i  (fe_job),
    .valid_i(fe_valid),
    .ready_o(fe_ready),
    .job_o  (q_job),
    .valid_o(q_valid),
    .ready_i(q_ready)
  );

  dmac_nd_midend i_nd_midend (
    .clk_i,
    .reset_i,
    .job_i        (q_job),
    .job_valid_i  (q_valid),
    .job_ready_o  (q_ready),
    .burst_o      (burst),
    .burst_valid_o(burst_valid),
    .burst_ready_i(burst_ready),
    .burst_done_i (burst_done),
    .job_done_o   (job_done),
    .busy_o       (mid_busy)
  );

  dmac_copy_engine i_copy_engine (
    .clk_i,
    .reset_i,
    .burst_i      (burst),
    .burst_valid_i(burst_valid),
    .burst_ready_o(burst_ready),
    .burst_done_o (burst_done),
    .mem_req_o,
    .mem_rsp_i,
    .busy_o       (eng_busy)
  );

endmodule

/* verification/tb_dmac.sv */
// dmac testbench
// memory model with random credit and read delay, register driver and checks
`timescale 1ns/1ps
`include "dmac_macros.svh"

module tb_dmac import dmac_pkg::*; ();

  localparam int MEM_WORDS = 256;
  localparam int NUM_JOBS  = 6;
  localparam int IMG_WORDS = 16;
  localparam int JOB_BASE  = 'h20;
  localparam int EXP_BASE  = 'h60;

  logic        clk_i;
  logic        reset_i;
  cfg_req_t    cfg_req;
  cfg_rsp_t    cfg_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic        done_event_o;
  logic        busy_o;

  logic [31:0] vec   [0:127];
  logic [31:0] mem   [0:MEM_WORDS-1];
  logic [31:0] model [0:MEM_WORDS-1];
  logic [31:0] read_data [$];
  int          read_due  [$];
  int          credit_wait;
  mem_rsp_t    rsp;
  int          outstanding;
  int          req_cnt;
  int          done_count;
  int          cycle_cnt;
  int          cycle_limit;
  int          error_cnt;
  int          check_cnt;

  dmac_top i_dmac_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_req_i   (cfg_req),
    .cfg_rsp_o   (cfg_rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp),
    .done_event_o(done_event_o),
    .busy_o      (busy_o)
  );

  always #10 clk_i = ~clk_i;

  // run limit from the word count of all jobs
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, jobs did not complete", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // memory model, requests are taken at the next rising edge
  always @(negedge clk_i) begin
    if (reset_i) begin
      read_data.delete();
      read_due.delete();
      outstanding = 0;
      credit_wait = 0;
      done_count  = 0;
      mem_rsp     = '0;
    end else begin
      if (done_event_o) begin
        done_count++;
      end
      rsp = '0;
      // one credit back, then a random gap of 0 to 3 cycles
      if (outstanding > 0) begin
        if (credit_wait == 0) begin
          rsp.credit  = 1'b1;
          credit_wait = int'($urandom % 4);
        end else begin
          credit_wait--;
        end
      end
      if (mem_req.valid) begin
        req_cnt++;
        if (outstanding >= `DMAC_MEM_CREDITS) begin
          error_cnt++;
          $display("memory request sent while %0d requests were outstanding", outstanding);
        end
        outstanding++;
        if (mem_req.addr >= MEM_WORDS) begin
          error_cnt++;
          $display("memory request to address %h outside the memory model", mem_req.addr);
        end
        if (mem_req.we) begin
          mem[mem_req.addr[7:0]] = mem_req.wdata;
        end else begin
          read_data.push_back(mem[mem_req.addr[7:0]]);
          read_due.push_back(cycle_cnt + 1 + int'($urandom % 4));
        end
      end
      // read data in order
      if (read_due.size() > 0 && read_due[0] <= cycle_cnt) begin
        rsp.rvalid = 1'b1;
        rsp.rdata  = read_data.pop_front();
        void'(read_due.pop_front());
      end
      if (rsp.credit) begin
        outstanding--;
      end
      mem_rsp = rsp;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // --------------------------------------------------
  // register port driver, called and returning on a falling edge
  task automatic reg_access(input logic write, input reg_addr_e addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    cfg_req.valid = 1'b1;
    cfg_req.write = write;
    cfg_req.addr  = addr;
    cfg_req.wdata = wdata;
    // a launch stalls here while the job queue is full
    do begin
      @(posedge clk_i);
    end while (!cfg_rsp.ready);
    @(negedge clk_i);
    cfg_req = '0;
    rdata   = cfg_rsp.rdata;
    if (!write) begin
      check_value($sformatf("rvalid %s", addr.name()), 32'd1, {31'd0, cfg_rsp.rvalid});
    end
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
    logic [31:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
    reg_access(1'b0, addr, 32'd0, data);
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    cfg_req = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
  endtask

  // reference copy, row r goes from src + r*src_stride to dst + r*dst_stride
  function automatic void apply_model(input int j);
    int src;
    int dst;
    int len;
    int sst;
    int dstr;
    int reps;
    src  = vec[JOB_BASE + 6*j];
    dst  = vec[JOB_BASE + 6*j + 1];
    len  = vec[JOB_BASE + 6*j + 2];
    sst  = vec[JOB_BASE + 6*j + 3];
    dstr = vec[JOB_BASE + 6*j + 4];
    reps = vec[JOB_BASE + 6*j + 5];
    for (int r = 0; r < reps; r++) begin
      for (int i = 0; i < len; i++) begin
        model[(dst + r*dstr + i) % MEM_WORDS] = model[(src + r*sst + i) % MEM_WORDS];
      end
    end
  endfunction

  task automatic launch_job(input int j, input logic [31:0] exp_id);
    logic [31:0] id;
    reg_write(SRC,        vec[JOB_BASE + 6*j]);
    reg_write(DST,        vec[JOB_BASE + 6*j + 1]);
    reg_write(LEN,        vec[JOB_BASE + 6*j + 2]);
    reg_write(SRC_STRIDE, vec[JOB_BASE + 6*j + 3]);
    reg_write(DST_STRIDE, vec[JOB_BASE + 6*j + 4]);
    reg_write(REPS,       vec[JOB_BASE + 6*j + 5]);
    reg_read(NEXT_ID, id);
    check_value($sformatf("next_id of job %0d", j), exp_id, id);
    apply_model(j);
  endtask

  task automatic wait_done(input int target);
    while (done_count < target) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic compare_memory(input string tag);
    for (int a = 0; a < MEM_WORDS; a++) begin
      check_value($sformatf("%s mem[%02h]", tag, a), model[a], mem[a]);
    end
  endtask

  // --------------------------------------------------
  // test sequence
  initial begin
    logic [31:0] rd;
    logic [15:0] a16;
    int          total_words;
    int          req_before;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    cfg_req     = '0;
    mem_rsp     = '0;
    cycle_cnt   = 0;
    error_cnt   = 0;
    check_cnt   = 0;
    req_cnt     = 0;
    rd          = $urandom(32'h9fb5_17ed);
    $readmemh("verification/dmac_vectors.txt", vec);
    total_words = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      total_words += vec[JOB_BASE + 6*j + 2] * vec[JOB_BASE + 6*j + 5];
    end
    cycle_limit = total_words * 20 + 500;
    // fill pattern, then the source image from the vectors
    for (int a = 0; a < MEM_WORDS; a++) begin
      a16    = 16'(a);
      mem[a] = {~a16, a16};
    end
    for (int i = 0; i < IMG_WORDS; i++) begin
      mem[vec[0] + i] = vec[1 + i];
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      model[a] = mem[a];
    end
    apply_reset();

    check_value("busy after reset", 32'd0, {31'd0, busy_o});
    check_value("done_event after reset", 32'd0, {31'd0, done_event_o});
    check_value("mem_req valid after reset", 32'd0, {31'd0, mem_req.valid});
    check_value("cfg rvalid after reset", 32'd0, {31'd0, cfg_rsp.rvalid});
    reg_read(DONE_ID, rd);
    check_value("done_id after reset", 32'd0, rd);
    reg_read(STATUS, rd);
    check_value("status after reset", 32'd0, rd);

    launch_job(0, 32'd1);
    wait_done(1);
    compare_memory("1d copy");

    launch_job(1, 32'd2);
    wait_done(2);
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 3; i++) begin
        check_value($sformatf("2d row %0d word %0d", r, i), vec[EXP_BASE + 3*r + i],
                    mem[vec[JOB_BASE + 7] + r*vec[JOB_BASE + 10] + i]);
      end
    end
    compare_memory("2d copy");

    // empty job must not touch memory
    req_before = req_cnt;
    launch_job(2, 32'd3);
    wait_done(3);
    reg_read(DONE_ID, rd);
    check_value("done_id after zero length job", 32'd3, rd);
    check_value("requests of zero length job", 32'(req_before), 32'(req_cnt));

    // three launches back to back on a fresh DUT
    apply_reset();
    launch_job(3, 32'd1);
    launch_job(4, 32'd2);
    launch_job(5, 32'd3);
    reg_read(STATUS, rd);
    check_value("status while jobs run", 32'd1, rd);
    wait_done(3);
    reg_read(DONE_ID, rd);
    check_value("done_id after back to back jobs", 32'd3, rd);
    check_value("done events", 32'd3, 32'(done_count));
    check_value("busy at end", 32'd0, {31'd0, busy_o});
    compare_memory("final");

    $display("checks %0d, errors %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verification/dmac_vectors.txt */
// hex words: @00 image base, then 16 image words; @20 six jobs, one per line
// job columns: src dst len src_stride dst_stride reps; @60 expected rows of job 1
@00
20
cafe0000 cafe0011 cafe0022 cafe0033 cafe0044 cafe0055 cafe0066 cafe0077
cafe0088 cafe0099 cafe00aa cafe00bb cafe00cc cafe00dd cafe00ee cafe00ff
@20
20 60 5 0 0 1
20 80 3 4 8 3
20 a0 0 1 1 2
2a b0 4 0 0 1
2c c0 2 1 4 2
21 d0 3 2 3 2
@60
cafe0000 cafe0011 cafe0022 cafe0044 cafe0055 cafe0066 cafe0088 cafe0099 cafe00aa

/* filelist.f */
+incdir+src
src/dmac_pkg.sv
src/dmac_reg_frontend.sv
src/dmac_id_counter.sv
src/dmac_job_queue.sv
src/dmac_nd_midend.sv
src/dmac_copy_engine.sv
src/dmac_top.sv
verification/tb_dmac.sv

/* run_sim.sh */
#!/bin/sh
# build the dmac testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dmac -f filelist.f -o sim_dmac

out=$(./obj_dir/sim_dmac)
echo "$out"

if echo "$out" | grep -q "Everything OK"; then
  exit 0
fi
exit 1
